/* hdl/decode_settings.svh */
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

// Datapath widths
`define INSTR_BITS        32
`define REG_ADDR_BITS     4   // RV32E style, 16 registers
`define REG_FIELD_BITS    5   // Encoded register field width
`define FUNCT3_BITS       3

// Instruction field positions
`define OPCODE_RANGE      6:0
`define RD_RANGE          11:7
`define FUNCT3_RANGE      14:12
`define RS1_RANGE         19:15
`define RS2_RANGE         24:20
`define FUNCT7_RANGE      31:25

// Major opcodes of the supported classes
`define OPC_LUI           7'b0110111
`define OPC_AUIPC         7'b0010111
`define OPC_JAL           7'b1101111
`define OPC_JALR          7'b1100111
`define OPC_BRANCH        7'b1100011
`define OPC_LOAD          7'b0000011
`define OPC_STORE         7'b0100011
`define OPC_OP_IMM        7'b0010011
`define OPC_OP            7'b0110011

`endif

/* hdl/imm_gen.sv */
`timescale 1ns/1ns
`default_nettype none

`include "decode_settings.svh"

module imm_gen (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        hold,
    input  rv_decode_pkg::instr_t       instr,
    input  rv_decode_pkg::instr_class_t instr_class,
    output rv_decode_pkg::instr_t       imm
);

    import rv_decode_pkg::*;

    instr_t imm_next;

    always_comb begin
        case (instr_class)
            CLASS_LUI, CLASS_AUIPC: begin
                imm_next = {instr[31:12], 12'b0};  // U-type
            end
            CLASS_JAL: begin
                imm_next = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            CLASS_BRANCH: begin
                imm_next = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            CLASS_STORE: begin
                imm_next = {{20{instr[31]}}, instr[`FUNCT7_RANGE], instr[`RD_RANGE]};
            end
            default: begin
                // I-type, also used for invalid words
                imm_next = {{20{instr[31]}}, instr[31:20]};
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            imm <= '0;
        end else if (!hold) begin
            imm <= imm_next;
        end
    end

endmodule

`default_nettype wire

/* hdl/instr_validate.sv */
`timescale 1ns/1ns
`default_nettype none

`include "decode_settings.svh"

module instr_validate (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        hold,
    input  rv_decode_pkg::instr_t       instr,
    input  rv_decode_pkg::instr_class_t instr_class,
    output logic                        invalid_instr,
    output logic                        fault
);

    import rv_decode_pkg::*;

    logic [`FUNCT3_BITS-1:0]    funct3;
    logic [6:0]                 funct7;
    logic [`REG_FIELD_BITS-1:0] rs1;
    logic [`REG_FIELD_BITS-1:0] rs2;
    logic [`REG_FIELD_BITS-1:0] rd;
    logic                       bad_funct;
    logic                       uses_rs1;
    logic                       uses_rs2;
    logic                       uses_rd;
    logic                       bad_reg;

    assign funct3 = instr[`FUNCT3_RANGE];
    assign funct7 = instr[`FUNCT7_RANGE];
    assign rs1    = instr[`RS1_RANGE];
    assign rs2    = instr[`RS2_RANGE];
    assign rd     = instr[`RD_RANGE];

    always_comb begin
        bad_funct = 1'b0;
        case (instr_class)
            CLASS_INVALID: begin
                bad_funct = 1'b1;
            end
            CLASS_JALR: begin
                bad_funct = (funct3 != 3'b000);
            end
            CLASS_LOAD: begin
                bad_funct = (funct3 inside {3'b011, 3'b110, 3'b111});
            end
            CLASS_STORE: begin
                bad_funct = funct3[2] | (funct3 == 3'b011);
            end
            CLASS_BRANCH: begin
                bad_funct = (funct3 inside {3'b010, 3'b011});
            end
            CLASS_OP: begin
                // Alternate encoding only for SUB and SRA
                bad_funct = (funct7 != 7'b0000000) &&
                    !((funct7 == 7'b0100000) && (funct3 inside {3'b000, 3'b101}));
            end
            CLASS_OP_IMM: begin
                if (funct3 == 3'b001) begin
                    bad_funct = (funct7 != 7'b0000000);  // SLLI
                end else if (funct3 == 3'b101) begin
                    bad_funct = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
                end
            end
            default: begin
                bad_funct = 1'b0;
            end
        endcase
    end

    // Only x0..x15 exist
    assign uses_rs1 = !(instr_class inside {CLASS_LUI, CLASS_AUIPC, CLASS_JAL});
    assign uses_rs2 = instr_class inside {CLASS_OP, CLASS_STORE, CLASS_BRANCH};
    assign uses_rd  = !(instr_class inside {CLASS_STORE, CLASS_BRANCH});

    assign bad_reg = (uses_rs1 & rs1[`REG_ADDR_BITS]) |
                     (uses_rs2 & rs2[`REG_ADDR_BITS]) |
                     (uses_rd & rd[`REG_ADDR_BITS]);

    assign invalid_instr = bad_funct | bad_reg;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fault <= 1'b0;
        end else if (!hold) begin
            fault <= invalid_instr;
        end
    end

endmodule

`default_nettype wire

/* hdl/instruction_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module instruction_decode (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            hold,
    input  rv_decode_pkg::instr_t           instr,
    output rv_decode_pkg::instr_t           imm,
    output rv_decode_pkg::rd_rf_microcode_t rd_rf_microcode,
    output rv_decode_pkg::alu_microcode_t   alu_microcode,
    output rv_decode_pkg::mem_microcode_t   mem_microcode,
    output rv_decode_pkg::wb_rf_microcode_t wb_rf_microcode,
    output logic                            alu_a_sel,
    output logic                            alu_b_sel,
    output rv_decode_pkg::wb_sel_t          wb_sel,
    output rv_decode_pkg::pc_sel_t          pc_sel,
    output logic                            fault
);

    import rv_decode_pkg::*;

    instr_class_t instr_class;
    logic         invalid_instr;  // Unregistered, gates the enables

    opcode_classify u_opcode_classify (
        .instr       (instr),
        .instr_class (instr_class)
    );

    instr_validate u_instr_validate (
        .clk           (clk),
        .arst_n        (arst_n),
        .hold          (hold),
        .instr         (instr),
        .instr_class   (instr_class),
        .invalid_instr (invalid_instr),
        .fault         (fault)
    );

    imm_gen u_imm_gen (
        .clk         (clk),
        .arst_n      (arst_n),
        .hold        (hold),
        .instr       (instr),
        .instr_class (instr_class),
        .imm         (imm)
    );

    microcode_gen u_microcode_gen (
        .clk             (clk),
        .arst_n          (arst_n),
        .hold            (hold),
        .instr           (instr),
        .instr_class     (instr_class),
        .invalid_instr   (invalid_instr),
        .rd_rf_microcode (rd_rf_microcode),
        .alu_microcode   (alu_microcode),
        .mem_microcode   (mem_microcode),
        .wb_rf_microcode (wb_rf_microcode),
        .alu_a_sel       (alu_a_sel),
        .alu_b_sel       (alu_b_sel),
        .wb_sel          (wb_sel),
        .pc_sel          (pc_sel)
    );

endmodule

`default_nettype wire

/* hdl/microcode_gen.sv */
`timescale 1ns/1ns
`default_nettype none

`include "decode_settings.svh"

module microcode_gen (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            hold,
    input  rv_decode_pkg::instr_t           instr,
    input  rv_decode_pkg::instr_class_t     instr_class,
    input  logic                            invalid_instr,
    output rv_decode_pkg::rd_rf_microcode_t rd_rf_microcode,
    output rv_decode_pkg::alu_microcode_t   alu_microcode,
    output rv_decode_pkg::mem_microcode_t   mem_microcode,
    output rv_decode_pkg::wb_rf_microcode_t wb_rf_microcode,
    output logic                            alu_a_sel,
    output logic                            alu_b_sel,
    output rv_decode_pkg::wb_sel_t          wb_sel,
    output rv_decode_pkg::pc_sel_t          pc_sel
);

    import rv_decode_pkg::*;

    logic [`FUNCT3_BITS-1:0]    funct3;
    logic [6:0]                 funct7;
    logic [`REG_FIELD_BITS-1:0] rs1;
    logic [`REG_FIELD_BITS-1:0] rs2;
    logic [`REG_FIELD_BITS-1:0] rd;
    logic                       is_arith;
    logic                       is_branch;
    logic                       alt;
    rd_rf_microcode_t           rd_rf_next;
    alu_microcode_t             alu_next;
    mem_microcode_t             mem_next;
    wb_rf_microcode_t           wb_rf_next;
    wb_sel_t                    wb_sel_next;
    pc_sel_t                    pc_sel_next;

    assign funct3 = instr[`FUNCT3_RANGE];
    assign funct7 = instr[`FUNCT7_RANGE];
    assign rs1    = instr[`RS1_RANGE];
    assign rs2    = instr[`RS2_RANGE];
    assign rd     = instr[`RD_RANGE];

    assign is_arith  = instr_class inside {CLASS_OP_IMM, CLASS_OP};
    assign is_branch = (instr_class == CLASS_BRANCH);

    // SUB, SRA and SRAI
    assign alt = funct7[5] & (((instr_class == CLASS_OP) && (funct3 inside {3'b000, 3'b101})) ||
                              ((instr_class == CLASS_OP_IMM) && (funct3 == 3'b101)));

    always_comb begin
        rd_rf_next.enable = !invalid_instr &&
            !(instr_class inside {CLASS_LUI, CLASS_AUIPC, CLASS_JAL});
        rd_rf_next.rs1    = rs1[`REG_ADDR_BITS-1:0];
        rd_rf_next.rs2    = rs2[`REG_ADDR_BITS-1:0];

        alu_next.enable          = !invalid_instr && (is_arith || is_branch ||
            (instr_class inside {CLASS_LOAD, CLASS_STORE, CLASS_AUIPC, CLASS_JALR}));
        alu_next.output_sel      = is_arith ? funct3 : (is_branch ? 3'b010 : 3'b000);
        alu_next.shifter_op      = {funct3[2] & alt, funct3[2]};
        alu_next.is_add_n        = is_branch | alt | alu_next.output_sel[1] |
                                   alu_next.output_sel[0];
        alu_next.is_beq_bne      = is_branch & ~funct3[2];
        alu_next.is_bge_bgeu_bne = is_branch & funct3[0];
        alu_next.is_sltu_bltu    = is_branch ? funct3[1] : (funct3[1] & funct3[0]);

        mem_next.enable   = !invalid_instr && (instr_class inside {CLASS_LOAD, CLASS_STORE});
        mem_next.is_store = (instr_class == CLASS_STORE);
        mem_next.funct3   = funct3;  // Access size and sign

        wb_rf_next.enable = !invalid_instr && !(instr_class inside {CLASS_STORE, CLASS_BRANCH});
        wb_rf_next.rd     = rd[`REG_ADDR_BITS-1:0];

        case (instr_class)
            CLASS_LUI:             wb_sel_next = WB_IMM;
            CLASS_LOAD:            wb_sel_next = WB_MEM;
            CLASS_JAL, CLASS_JALR: wb_sel_next = WB_NPC;  // Link address
            default:               wb_sel_next = WB_ALU;
        endcase

        case (instr_class)
            CLASS_JALR:   pc_sel_next = PC_JALR;
            CLASS_JAL:    pc_sel_next = PC_REL;
            CLASS_BRANCH: pc_sel_next = PC_BRANCH;
            default:      pc_sel_next = PC_NPC;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_rf_microcode <= '0;
            alu_microcode   <= '0;
            mem_microcode   <= '0;
            wb_rf_microcode <= '0;
            alu_a_sel       <= 1'b0;
            alu_b_sel       <= 1'b0;
            wb_sel          <= WB_ALU;
            pc_sel          <= PC_NPC;
        end else if (!hold) begin
            rd_rf_microcode <= rd_rf_next;
            alu_microcode   <= alu_next;
            mem_microcode   <= mem_next;
            wb_rf_microcode <= wb_rf_next;
            alu_a_sel       <= (instr_class == CLASS_AUIPC);  // PC as operand A
            alu_b_sel       <= !(is_branch || (instr_class == CLASS_OP));
            wb_sel          <= wb_sel_next;
            pc_sel          <= pc_sel_next;
        end
    end

    // Memory stage needs the ALU address
    mem_needs_alu_a: assert property (
        @(posedge clk) disable iff (!arst_n)
        !hold |=> (!mem_microcode.enable || alu_microcode.enable)
    ) else $error("memory enable without ALU enable");

endmodule

`default_nettype wire

/* hdl/opcode_classify.sv */
`timescale 1ns/1ns
`default_nettype none

`include "decode_settings.svh"

module opcode_classify (
    input  rv_decode_pkg::instr_t       instr,
    output rv_decode_pkg::instr_class_t instr_class
);

    import rv_decode_pkg::*;

    logic [6:0] opcode;

    assign opcode = instr[`OPCODE_RANGE];

    // SYSTEM and FENCE fall through to invalid
    always_comb begin
        case (opcode)
            `OPC_LUI: begin
                instr_class = CLASS_LUI;
            end
            `OPC_AUIPC: begin
                instr_class = CLASS_AUIPC;
            end
            `OPC_JAL: begin
                instr_class = CLASS_JAL;
            end
            `OPC_JALR: begin
                instr_class = CLASS_JALR;
            end
            `OPC_BRANCH: begin
                instr_class = CLASS_BRANCH;
            end
            `OPC_LOAD: begin
                instr_class = CLASS_LOAD;
            end
            `OPC_STORE: begin
                instr_class = CLASS_STORE;
            end
            `OPC_OP_IMM: begin
                instr_class = CLASS_OP_IMM;
            end
            `OPC_OP: begin
                instr_class = CLASS_OP;
            end
            default: begin
                instr_class = CLASS_INVALID;  // Also catches bits 1:0 != 11
            end
        endcase
    end

    // An X opcode would land in the default arm and pass as a plain invalid class
    opcode_known_a: assert final (!$isunknown(opcode))
        else $error("opcode is unknown");

endmodule

`default_nettype wire

/* hdl/rv_decode_pkg.sv */
`default_nettype none

`include "decode_settings.svh"

package rv_decode_pkg;

    typedef logic [`INSTR_BITS-1:0] instr_t;

    typedef enum logic [3:0] {
        CLASS_INVALID = 4'd0,
        CLASS_LUI     = 4'd1,
        CLASS_AUIPC   = 4'd2,
        CLASS_JAL     = 4'd3,
        CLASS_JALR    = 4'd4,
        CLASS_BRANCH  = 4'd5,
        CLASS_LOAD    = 4'd6,
        CLASS_STORE   = 4'd7,
        CLASS_OP_IMM  = 4'd8,
        CLASS_OP      = 4'd9
    } instr_class_t;

    // Read stage
    typedef struct packed {
        logic                      enable;
        logic [`REG_ADDR_BITS-1:0] rs1;
        logic [`REG_ADDR_BITS-1:0] rs2;
    } rd_rf_microcode_t;

    // Execute stage
    typedef struct packed {
        logic                    enable;
        logic                    is_beq_bne;
        logic                    is_bge_bgeu_bne;
        logic                    is_sltu_bltu;
        logic                    is_add_n;
        logic [1:0]              shifter_op;
        logic [`FUNCT3_BITS-1:0] output_sel;
    } alu_microcode_t;

    // Memory access stage
    typedef struct packed {
        logic                    enable;
        logic                    is_store;
        logic [`FUNCT3_BITS-1:0] funct3;
    } mem_microcode_t;

    // Write back stage
    typedef struct packed {
        logic                      enable;
        logic [`REG_ADDR_BITS-1:0] rd;
    } wb_rf_microcode_t;

    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_IMM = 2'd1,
        WB_MEM = 2'd2,
        WB_NPC = 2'd3
    } wb_sel_t;

    typedef enum logic [1:0] {
        PC_NPC    = 2'd0,
        PC_JALR   = 2'd1,  // Target from rs1 + imm
        PC_REL    = 2'd2,
        PC_BRANCH = 2'd3   // Taken ? pc + imm : npc
    } pc_sel_t;

endpackage

`default_nettype wire

/* list.f */
+incdir+hdl
+incdir+verification
hdl/rv_decode_pkg.sv
hdl/opcode_classify.sv
hdl/instr_validate.sv
hdl/imm_gen.sv
hdl/microcode_gen.sv
hdl/instruction_decode.sv
verification/tb_instruction_decode.sv

/* verification/decode_model.svh */
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// Everything the decoder registers for one instruction
typedef struct packed {
    instr_t           imm;
    rd_rf_microcode_t rd_rf;
    alu_microcode_t   alu;
    mem_microcode_t   mem;
    wb_rf_microcode_t wb_rf;
    logic             alu_a_sel;
    logic             alu_b_sel;
    wb_sel_t          wb_sel;
    pc_sel_t          pc_sel;
    logic             fault;
} decode_expect_t;

function automatic instr_class_t class_of(instr_t w);
    case (w[6:0])
        7'h37:   return CLASS_LUI;
        7'h17:   return CLASS_AUIPC;
        7'h6f:   return CLASS_JAL;
        7'h67:   return CLASS_JALR;
        7'h63:   return CLASS_BRANCH;
        7'h03:   return CLASS_LOAD;
        7'h23:   return CLASS_STORE;
        7'h13:   return CLASS_OP_IMM;
        7'h33:   return CLASS_OP;
        default: return CLASS_INVALID;
    endcase
endfunction

function automatic decode_expect_t decode_model(instr_t w);
    decode_expect_t e;
    instr_class_t   c;
    logic [2:0]     f3;
    logic [6:0]     f7;
    logic           arith;
    logic           br;
    logic           alt;
    logic           bad;
    e     = '0;
    c     = class_of(w);
    f3    = w[14:12];
    f7    = w[31:25];
    arith = (c == CLASS_OP_IMM) || (c == CLASS_OP);
    br    = (c == CLASS_BRANCH);
    bad   = (c == CLASS_INVALID);
    case (c)
        CLASS_JALR:   bad = (f3 != 3'd0);
        CLASS_LOAD:   bad = (f3 == 3'd3) || (f3 >= 3'd6);
        CLASS_STORE:  bad = (f3 >= 3'd3);  // Only SB, SH, SW
        CLASS_BRANCH: bad = (f3 == 3'd2) || (f3 == 3'd3);
        CLASS_OP:     bad = !((f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5))));
        CLASS_OP_IMM: begin
            if (f3 == 3'd1) bad = (f7 != 7'h00);
            else if (f3 == 3'd5) bad = !((f7 == 7'h00) || (f7 == 7'h20));
        end
        default: begin
        end
    endcase
    if (w[19] && !(c inside {CLASS_LUI, CLASS_AUIPC, CLASS_JAL})) bad = 1'b1;
    if (w[24] && (c inside {CLASS_OP, CLASS_STORE, CLASS_BRANCH})) bad = 1'b1;
    if (w[11] && !(c inside {CLASS_STORE, CLASS_BRANCH})) bad = 1'b1;
    e.fault = bad;

    case (c)
        CLASS_LUI, CLASS_AUIPC: e.imm = {w[31:12], 12'h000};
        CLASS_JAL:    e.imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        CLASS_BRANCH: e.imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        CLASS_STORE:  e.imm = {{20{w[31]}}, w[31:25], w[11:7]};
        default:      e.imm = {{20{w[31]}}, w[31:20]};
    endcase

    e.rd_rf.enable = !bad && !(c inside {CLASS_LUI, CLASS_AUIPC, CLASS_JAL});
    e.rd_rf.rs1    = w[18:15];
    e.rd_rf.rs2    = w[23:20];

    alt = f7[5] && (((c == CLASS_OP) && ((f3 == 3'd0) || (f3 == 3'd5))) ||
                    ((c == CLASS_OP_IMM) && (f3 == 3'd5)));
    e.alu.enable          = !bad && (arith || br ||
                            (c inside {CLASS_LOAD, CLASS_STORE, CLASS_AUIPC, CLASS_JALR}));
    e.alu.output_sel      = arith ? f3 : (br ? 3'b010 : 3'b000);
    e.alu.shifter_op      = {f3[2] && alt, f3[2]};
    e.alu.is_add_n        = br || alt || (e.alu.output_sel[1:0] != 2'b00);
    e.alu.is_beq_bne      = br && !f3[2];
    e.alu.is_bge_bgeu_bne = br && f3[0];
    e.alu.is_sltu_bltu    = br ? f3[1] : (f3[1] && f3[0]);

    e.mem.enable   = !bad && ((c == CLASS_LOAD) || (c == CLASS_STORE));
    e.mem.is_store = (c == CLASS_STORE);
    e.mem.funct3   = f3;

    e.wb_rf.enable = !bad && !br && (c != CLASS_STORE);
    e.wb_rf.rd     = w[10:7];

    e.alu_a_sel = (c == CLASS_AUIPC);
    e.alu_b_sel = !(br || (c == CLASS_OP));
    e.wb_sel    = (c == CLASS_LUI) ? WB_IMM :
                  (c == CLASS_LOAD) ? WB_MEM :
                  ((c == CLASS_JAL) || (c == CLASS_JALR)) ? WB_NPC : WB_ALU;
    e.pc_sel    = (c == CLASS_JALR) ? PC_JALR :
                  (c == CLASS_JAL) ? PC_REL :
                  br ? PC_BRANCH : PC_NPC;
    return e;
endfunction

`endif

/* verification/tb_instruction_decode.sv */
`timescale 1ns/1ns
`default_nettype none

`include "decode_settings.svh"

module tb_instruction_decode;

    import rv_decode_pkg::*;

    `include "decode_model.svh"

    localparam int CLK_PERIOD    = 40;
    localparam int RESET_CYCLES  = 5;
    localparam int PER_CLASS     = 20;
    localparam int N_BAD_OPC     = 60;
    localparam int N_BAD_FIELD   = 80;
    localparam int HOLD_ROUNDS   = 8;
    localparam int HOLD_LEN      = 4;
    localparam int N_STREAM      = 150;
    localparam int STIM_CYCLES   = 2 + 9 * PER_CLASS + N_BAD_OPC + N_BAD_FIELD +
                                   HOLD_ROUNDS * (HOLD_LEN + 1) + N_STREAM + 2;
    localparam int WATCHDOG_NS   = (2 * STIM_CYCLES + RESET_CYCLES) * CLK_PERIOD;

    logic             clk;
    logic             arst_n;
    logic             hold;
    instr_t           instr;
    instr_t           imm;
    rd_rf_microcode_t rd_rf_microcode;
    alu_microcode_t   alu_microcode;
    mem_microcode_t   mem_microcode;
    wb_rf_microcode_t wb_rf_microcode;
    logic             alu_a_sel;
    logic             alu_b_sel;
    wb_sel_t          wb_sel;
    pc_sel_t          pc_sel;
    logic             fault;

    instruction_decode dut (
        .clk             (clk),
        .arst_n          (arst_n),
        .hold            (hold),
        .instr           (instr),
        .imm             (imm),
        .rd_rf_microcode (rd_rf_microcode),
        .alu_microcode   (alu_microcode),
        .mem_microcode   (mem_microcode),
        .wb_rf_microcode (wb_rf_microcode),
        .alu_a_sel       (alu_a_sel),
        .alu_b_sel       (alu_b_sel),
        .wb_sel          (wb_sel),
        .pc_sel          (pc_sel),
        .fault           (fault)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run();
        $display("Something failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(string name, string exp_s, string act_s);
        $display("ERR %0t ns: %s expected %s actual %s", $time, name, exp_s, act_s);
        abort_run();
    endtask

    task automatic imm_check(instr_t exp, instr_t act);
        if (act !== exp) report_mismatch("imm", $sformatf("%h", exp), $sformatf("%h", act));
    endtask

    task automatic rd_rf_check(rd_rf_microcode_t exp, rd_rf_microcode_t act);
        if (act !== exp) begin
            report_mismatch("rd_rf_microcode", $sformatf("%h", exp), $sformatf("%h", act));
        end
    endtask

    task automatic alu_check(alu_microcode_t exp, alu_microcode_t act);
        if (act !== exp) begin
            report_mismatch("alu_microcode", $sformatf("%h", exp), $sformatf("%h", act));
        end
    endtask

    task automatic mem_check(mem_microcode_t exp, mem_microcode_t act);
        if (act !== exp) begin
            report_mismatch("mem_microcode", $sformatf("%h", exp), $sformatf("%h", act));
        end
    endtask

    task automatic wb_rf_check(wb_rf_microcode_t exp, wb_rf_microcode_t act);
        if (act !== exp) begin
            report_mismatch("wb_rf_microcode", $sformatf("%h", exp), $sformatf("%h", act));
        end
    endtask

    task automatic wb_sel_check(wb_sel_t exp, wb_sel_t act);
        if (act !== exp) report_mismatch("wb_sel", $sformatf("%h", exp), $sformatf("%h", act));
    endtask

    task automatic pc_sel_check(pc_sel_t exp, pc_sel_t act);
        if (act !== exp) report_mismatch("pc_sel", $sformatf("%h", exp), $sformatf("%h", act));
    endtask

    task automatic bit_check(string name, logic exp, logic act);
        if (act !== exp) report_mismatch(name, $sformatf("%b", exp), $sformatf("%b", act));
    endtask

    // Unknown opcodes only promise fault and the stage enables
    task automatic check_outputs(decode_expect_t e, logic full);
        bit_check("fault", e.fault, fault);
        bit_check("rd_rf_microcode.enable", e.rd_rf.enable, rd_rf_microcode.enable);
        bit_check("alu_microcode.enable", e.alu.enable, alu_microcode.enable);
        bit_check("mem_microcode.enable", e.mem.enable, mem_microcode.enable);
        bit_check("wb_rf_microcode.enable", e.wb_rf.enable, wb_rf_microcode.enable);
        if (full) begin
            imm_check(e.imm, imm);
            rd_rf_check(e.rd_rf, rd_rf_microcode);
            alu_check(e.alu, alu_microcode);
            mem_check(e.mem, mem_microcode);
            wb_rf_check(e.wb_rf, wb_rf_microcode);
            bit_check("alu_a_sel", e.alu_a_sel, alu_a_sel);
            bit_check("alu_b_sel", e.alu_b_sel, alu_b_sel);
            wb_sel_check(e.wb_sel, wb_sel);
            pc_sel_check(e.pc_sel, pc_sel);
        end
    endtask

    function automatic instr_t legal_word(instr_class_t c);
        instr_t     w;
        logic [2:0] f3;
        w  = $urandom;
        f3 = $urandom;
        case (c)
            CLASS_LUI:   w[6:0] = `OPC_LUI;
            CLASS_AUIPC: w[6:0] = `OPC_AUIPC;
            CLASS_JAL:   w[6:0] = `OPC_JAL;
            CLASS_JALR: begin
                w[6:0] = `OPC_JALR;
                f3 = 3'd0;
            end
            CLASS_BRANCH: begin
                w[6:0] = `OPC_BRANCH;
                while ((f3 == 3'd2) || (f3 == 3'd3)) f3 = $urandom;
            end
            CLASS_LOAD: begin
                w[6:0] = `OPC_LOAD;
                while ((f3 == 3'd3) || (f3 >= 3'd6)) f3 = $urandom;
            end
            CLASS_STORE: begin
                w[6:0] = `OPC_STORE;
                f3 = $urandom_range(0, 2);
            end
            CLASS_OP_IMM: begin
                w[6:0] = `OPC_OP_IMM;
                if (f3 == 3'd1) w[31:25] = 7'h00;
                if (f3 == 3'd5) w[31:25] = {1'b0, 1'($urandom), 5'b0};  // SRLI or SRAI
            end
            default: begin
                w[6:0]   = `OPC_OP;
                w[31:25] = ((f3 == 3'd0) || (f3 == 3'd5)) ? {1'b0, 1'($urandom), 5'b0} : 7'h00;
            end
        endcase
        if (!(c inside {CLASS_LUI, CLASS_AUIPC, CLASS_JAL})) begin
            w[14:12] = f3;
            w[19]    = 1'b0;
        end
        if (c inside {CLASS_OP, CLASS_STORE, CLASS_BRANCH}) w[24] = 1'b0;
        if (!(c inside {CLASS_STORE, CLASS_BRANCH})) w[11] = 1'b0;
        return w;
    endfunction

    function automatic instr_t bad_opcode_word();
        instr_t w;
        w = $urandom;
        case ($urandom_range(0, 2))
            0: w[6:0] = 7'b1110011;  // SYSTEM
            1: w[6:0] = 7'b0001111;  // FENCE
            default: begin
                while (class_of(w) != CLASS_INVALID) w = $urandom;
            end
        endcase
        return w;
    endfunction

    // Legal opcode with one field broken
    function automatic instr_t bad_field_word();
        instr_t         w;
        decode_expect_t e;
        do begin
            w = legal_word(instr_class_t'($urandom_range(1, 9)));
            case ($urandom_range(0, 4))
                0: w[19] = 1'b1;
                1: w[24] = 1'b1;
                2: w[11] = 1'b1;
                3: w[14:12] = $urandom;
                default: w[31:25] = $urandom;
            endcase
            e = decode_model(w);
        end while (!e.fault);
        return w;
    endfunction

    function automatic instr_t mixed_word();
        case ($urandom_range(0, 3))
            0: return bad_opcode_word();
            1: return bad_field_word();
            default: return legal_word(instr_class_t'($urandom_range(1, 9)));
        endcase
    endfunction

    task automatic drive(instr_t w, logic h);
        @(negedge clk);
        instr = w;
        hold  = h;
    endtask

    // Compares mid cycle against the last accepted word
    initial begin
        instr_t last;
        logic   have;
        logic   full;
        last = '0;
        have = 1'b0;
        full = 1'b1;
        forever begin
            @(posedge clk);
            if (!arst_n) begin
                have = 1'b0;
            end else if (!hold) begin
                last = instr;
                have = 1'b1;
                full = (class_of(instr) != CLASS_INVALID);
            end
            @(negedge clk);
            if (have) check_outputs(decode_model(last), full);
            else check_outputs('0, 1'b1);  // Reset values
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the test sequence completed");
        abort_run();
    end

    initial begin
        void'($urandom(32'h9a9a_e81b));
        arst_n     = 1'b0;
        hold       = 1'b1;
        instr      = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        arst_n = 1'b1;
        repeat (2) drive($urandom, 1'b1);  // Outputs stay at reset values
        for (int c = 1; c <= 9; c++) begin
            repeat (PER_CLASS) drive(legal_word(instr_class_t'(c)), 1'b0);
        end
        repeat (N_BAD_OPC) drive(bad_opcode_word(), 1'b0);
        repeat (N_BAD_FIELD) drive(bad_field_word(), 1'b0);
        repeat (HOLD_ROUNDS) begin
            drive(legal_word(instr_class_t'($urandom_range(1, 9))), 1'b0);
            repeat (HOLD_LEN) drive($urandom, 1'b1);
        end
        repeat (N_STREAM) drive(mixed_word(), 1'b0);
        repeat (2) drive($urandom, 1'b1);
        @(posedge clk);
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire
